// ==== src/rv_core_params.svh ====
/*
 * Core-wide constants: data width, register count,
 * reset program counter and instruction length.
 */

`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// Data and address width.
`define RV_XLEN 32

`define RV_NR_REGS 32

`define RV_PC_START 32'h8000_0000

`define RV_INSTR_BYTES 4

`endif

// ==== src/rv_core_pkg.sv ====
/*
 * Shared types of the RV32I core: data words, register indices,
 * opcodes, instruction classes, ALU operations, branch conditions,
 * memory access sizes and operand selects.
 */

`default_nettype none

`include "rv_core_params.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [3:0] byte_en_t;

    // Major opcodes, instr[6:0].
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // Nine classes need a fourth bit.
    typedef enum logic [3:0] {
        CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR, CLS_BRANCH,
        CLS_LOAD, CLS_STORE, CLS_ALU, CLS_NOP
    } instr_class_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    // Encoded as the branch funct3.
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_e;

    typedef enum logic [1:0] {SIZE_BYTE = 2'b00, SIZE_HALF = 2'b01, SIZE_WORD = 2'b10} mem_size_e;

    typedef enum logic [1:0] {OP2_IMM, OP2_RS2, OP2_SHAMT} op2_sel_e;

endpackage

`default_nettype wire

// ==== src/rv_decode.sv ====
/*
 * Instruction decoder: registers the register indices, the
 * immediate and the control fields of the fetched word.
 */

`timescale 1ns/1ns
`default_nettype none

`include "rv_core_params.svh"

module rv_decode
    import rv_core_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst,
    input  logic         i_capture,
    input  word_t        i_instr,
    output reg_idx_t     o_rs1,
    output reg_idx_t     o_rs2,
    output reg_idx_t     o_rd,
    output word_t        o_imm,
    output instr_class_e o_class,
    output alu_op_e      o_alu_op,
    output logic         o_op1_is_pc,
    output op2_sel_e     o_op2_sel,
    output branch_e      o_branch_cond,
    output mem_size_e    o_mem_size,
    output logic         o_mem_unsigned
);

    opcode_e      opcode;
    logic [2:0]   funct3;
    logic [6:0]   funct7;
    word_t        imm_i, imm_s, imm_b, imm_u, imm_j;
    word_t        imm_d;
    instr_class_e cls_d;
    alu_op_e      alu_d;
    logic         op1_pc_d;
    op2_sel_e     op2_d;

    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode = opcode_e'(i_instr[6:0]);
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    assign imm_i = {{(`RV_XLEN-12){i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{(`RV_XLEN-12){i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{(`RV_XLEN-12){i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{(`RV_XLEN-20){i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21],
                    1'b0};

    // Illegal funct fields fall through to NOP.
    always_comb begin
        cls_d    = CLS_NOP;
        alu_d    = ALU_ADD;
        op1_pc_d = 1'b0;
        op2_d    = OP2_IMM;
        imm_d    = imm_i;
        case (opcode)
            OPC_LUI: begin
                cls_d = CLS_LUI;
                imm_d = imm_u;
            end
            OPC_AUIPC: begin
                cls_d    = CLS_AUIPC;
                op1_pc_d = 1'b1;
                imm_d    = imm_u;
            end
            OPC_JAL: begin
                cls_d    = CLS_JAL;
                op1_pc_d = 1'b1;
                imm_d    = imm_j;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) cls_d = CLS_JALR;
            end
            OPC_BRANCH: begin
                if (funct3[2:1] != 2'b01) cls_d = CLS_BRANCH;
                op1_pc_d = 1'b1;
                imm_d    = imm_b;
            end
            OPC_LOAD: begin
                if (funct3 != 3'b011 && funct3[2:1] != 2'b11) cls_d = CLS_LOAD;
            end
            OPC_STORE: begin
                if (!funct3[2] && funct3[1:0] != 2'b11) cls_d = CLS_STORE;
                imm_d = imm_s;
            end
            OPC_OP_IMM: begin
                if (funct3 == 3'b001 && funct7 != 7'b0000000) begin
                    cls_d = CLS_NOP;
                end else if (funct3 == 3'b101 && (funct7 & 7'b1011111) != 7'b0000000) begin
                    cls_d = CLS_NOP;
                end else begin
                    cls_d = CLS_ALU;
                end
                alu_d = alu_from_funct(funct3, funct3 == 3'b101 && i_instr[30]);
                op2_d = (funct3[1:0] == 2'b01) ? OP2_SHAMT : OP2_IMM;
            end
            OPC_OP: begin
                if (funct7 == 7'b0000000 ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    cls_d = CLS_ALU;
                end
                alu_d = alu_from_funct(funct3, i_instr[30]);
                op2_d = OP2_RS2;
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_class <= CLS_NOP;
        end else if (i_capture) begin
            o_class        <= cls_d;
            o_rs1          <= i_instr[19:15];
            o_rs2          <= i_instr[24:20];
            o_rd           <= i_instr[11:7];
            o_imm          <= imm_d;
            o_alu_op       <= alu_d;
            o_op1_is_pc    <= op1_pc_d;
            o_op2_sel      <= op2_d;
            o_branch_cond  <= branch_e'(funct3);
            o_mem_size     <= mem_size_e'(funct3[1:0]);
            o_mem_unsigned <= funct3[2];
        end
    end

endmodule

`default_nettype wire

// ==== src/rv_regfile.sv ====
/*
 * General register file, two asynchronous read ports and one
 * write port, x0 hardwired to zero.
 */

`timescale 1ns/1ns
`default_nettype none

`include "rv_core_params.svh"

module rv_regfile
    import rv_core_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_we,
    input  reg_idx_t i_waddr,
    input  word_t    i_wdata,
    input  reg_idx_t i_raddr1,
    input  reg_idx_t i_raddr2,
    output word_t    o_rdata1,
    output word_t    o_rdata2
);

    word_t regs [`RV_NR_REGS];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < `RV_NR_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata1 = regs[i_raddr1];
    assign o_rdata2 = regs[i_raddr2];

endmodule

`default_nettype wire

// ==== src/rv_execute.sv ====
/*
 * Execute unit: operand selection, ALU and branch comparison,
 * registered in a prepare step and an execute step.
 */

`timescale 1ns/1ns
`default_nettype none

`include "rv_core_params.svh"

module rv_execute
    import rv_core_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_prepare,
    input  logic     i_execute,
    input  word_t    i_pc,
    input  word_t    i_rs1_val,
    input  word_t    i_rs2_val,
    input  word_t    i_imm,
    input  reg_idx_t i_shamt,
    input  alu_op_e  i_alu_op,
    input  logic     i_op1_is_pc,
    input  op2_sel_e i_op2_sel,
    input  branch_e  i_branch_cond,
    output word_t    o_alu_result,
    output logic     o_branch_taken
);

    word_t op1, op2;
    word_t cmp_a, cmp_b;
    word_t alu_d;
    logic  eq, ge, geu;
    logic  taken_d;

    always_ff @(posedge i_clk) begin
        if (i_prepare) begin
            op1   <= i_op1_is_pc ? i_pc : i_rs1_val;
            cmp_a <= i_rs1_val;
            cmp_b <= i_rs2_val;
            case (i_op2_sel)
                OP2_RS2:   op2 <= i_rs2_val;
                OP2_SHAMT: op2 <= {{(`RV_XLEN-5){1'b0}}, i_shamt};
                default:   op2 <= i_imm;
            endcase
        end
    end

    always_comb begin
        case (i_alu_op)
            ALU_SUB:  alu_d = op1 - op2;
            ALU_SLT:  alu_d = word_t'($signed(op1) < $signed(op2));
            ALU_SLTU: alu_d = word_t'(op1 < op2);
            ALU_XOR:  alu_d = op1 ^ op2;
            ALU_OR:   alu_d = op1 | op2;
            ALU_AND:  alu_d = op1 & op2;
            ALU_SLL:  alu_d = op1 << op2[4:0];
            ALU_SRL:  alu_d = op1 >> op2[4:0];
            ALU_SRA:  alu_d = word_t'($signed(op1) >>> op2[4:0]);
            default:  alu_d = op1 + op2;
        endcase
    end

    // Branch compares the raw register values, not the ALU operands.
    assign eq  = (cmp_a == cmp_b);
    assign ge  = ($signed(cmp_a) >= $signed(cmp_b));
    assign geu = (cmp_a >= cmp_b);

    always_comb begin
        case (i_branch_cond)
            BR_EQ:   taken_d = eq;
            BR_NE:   taken_d = !eq;
            BR_LT:   taken_d = !ge;
            BR_GE:   taken_d = ge;
            BR_LTU:  taken_d = !geu;
            BR_GEU:  taken_d = geu;
            default: taken_d = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_execute) begin
            o_alu_result   <= alu_d;
            o_branch_taken <= taken_d;
        end
    end

endmodule

`default_nettype wire

// ==== src/rv_result.sv ====
/*
 * Memory result unit: store lane placement, load extraction
 * with sign or zero extension, and writeback selection.
 */

`timescale 1ns/1ns
`default_nettype none

`include "rv_core_params.svh"

module rv_result
    import rv_core_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_access,
    input  instr_class_e i_class,
    input  word_t        i_addr,
    input  word_t        i_rs2_val,
    input  word_t        i_load_data,
    input  word_t        i_alu_result,
    input  word_t        i_imm,
    input  word_t        i_link,
    input  mem_size_e    i_mem_size,
    input  logic         i_mem_unsigned,
    output word_t        o_store_data,
    output byte_en_t     o_store_wen,
    output word_t        o_wb_data,
    output logic         o_wb_en
);

    logic [1:0] addr_lo;
    logic [4:0] lane_shift;
    word_t      store_d;
    byte_en_t   wen_d;
    word_t      load_shifted;
    word_t      load_val;

    // Bit offset of the addressed lane.
    assign lane_shift = {i_addr[1:0], 3'b000};

    always_comb begin
        case (i_mem_size)
            SIZE_BYTE: begin
                store_d = {{(`RV_XLEN-8){1'b0}}, i_rs2_val[7:0]} << lane_shift;
                wen_d   = 4'b0001 << i_addr[1:0];
            end
            SIZE_HALF: begin
                store_d = {{(`RV_XLEN-16){1'b0}}, i_rs2_val[15:0]} << {i_addr[1], 4'b0000};
                wen_d   = i_addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                store_d = i_rs2_val;
                wen_d   = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_access) begin
            o_store_data <= store_d;
            o_store_wen  <= (i_class == CLS_STORE) ? wen_d : 4'b0000;
            addr_lo      <= i_addr[1:0];
        end
    end

    assign load_shifted = i_load_data >> {addr_lo, 3'b000};

    always_comb begin
        case (i_mem_size)
            SIZE_BYTE: begin
                load_val = {{(`RV_XLEN-8){!i_mem_unsigned && load_shifted[7]}},
                            load_shifted[7:0]};
            end
            SIZE_HALF: begin
                load_val = {{(`RV_XLEN-16){!i_mem_unsigned && load_shifted[15]}},
                            load_shifted[15:0]};
            end
            default: load_val = i_load_data;
        endcase
    end

    always_comb begin
        case (i_class)
            CLS_LUI:           o_wb_data = i_imm;
            CLS_JAL, CLS_JALR: o_wb_data = i_link;
            CLS_LOAD:          o_wb_data = load_val;
            default:           o_wb_data = i_alu_result;
        endcase
    end

    assign o_wb_en = (i_class != CLS_BRANCH) && (i_class != CLS_STORE) && (i_class != CLS_NOP);

endmodule

`default_nettype wire

// ==== src/rv_core.sv ====
/*
 * RV32I multi-cycle core: stage sequencer, program counter,
 * memory port and the decode, register, execute and result units.
 */

`timescale 1ns/1ns
`default_nettype none

`include "rv_core_params.svh"

module rv_core
    import rv_core_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst,
    output logic     o_mem_valid,
    input  logic     i_mem_ready,
    output word_t    o_mem_addr,
    input  word_t    i_mem_data,
    output word_t    o_mem_data,
    output byte_en_t o_mem_wen
);

    typedef enum logic [2:0] {
        ST_FETCH, ST_DECODE, ST_PREPARE, ST_EXECUTE, ST_ACCESS, ST_WRITEBACK
    } stage_e;

    stage_e       stage;
    word_t        pc, pc_inc, next_pc;
    logic         mem_valid, mem_rw;
    word_t        mem_addr, mem_rdata;
    logic         advance, capture, prepare, execute, access, rf_we;
    logic         is_mem, jump;
    reg_idx_t     rs1, rs2, rd;
    word_t        imm;
    instr_class_e cls;
    alu_op_e      alu_op;
    logic         op1_is_pc;
    op2_sel_e     op2_sel;
    branch_e      branch_cond;
    mem_size_e    mem_size;
    logic         mem_unsigned;
    word_t        rs1_val, rs2_val, alu_result, store_data, wb_data;
    logic         branch_taken, wb_en;
    byte_en_t     store_wen;

    // Stages hold while a memory request waits for ready.
    assign advance = !mem_valid;
    assign capture = advance && (stage == ST_DECODE);
    assign prepare = advance && (stage == ST_PREPARE);
    assign execute = advance && (stage == ST_EXECUTE);
    assign access  = advance && (stage == ST_ACCESS);
    assign rf_we   = advance && (stage == ST_WRITEBACK) && wb_en;

    assign is_mem  = (cls == CLS_LOAD) || (cls == CLS_STORE);
    assign jump    = (cls == CLS_JAL) || (cls == CLS_JALR) ||
                     ((cls == CLS_BRANCH) && branch_taken);
    assign pc_inc  = pc + word_t'(`RV_INSTR_BYTES);
    assign next_pc = jump ? alu_result : pc_inc;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            stage     <= ST_FETCH;
            pc        <= `RV_PC_START;
            mem_valid <= 1'b0;
            mem_rw    <= 1'b0;
        end else begin
            if (mem_valid && i_mem_ready) begin
                mem_valid <= 1'b0;
                mem_rw    <= 1'b0;
            end
            if (advance) begin
                case (stage)
                    ST_FETCH: begin
                        mem_valid <= 1'b1;
                        stage     <= ST_DECODE;
                    end
                    ST_DECODE:  stage <= ST_PREPARE;
                    ST_PREPARE: stage <= ST_EXECUTE;
                    ST_EXECUTE: stage <= is_mem ? ST_ACCESS : ST_WRITEBACK;
                    ST_ACCESS: begin
                        mem_valid <= 1'b1;
                        mem_rw    <= 1'b1;
                        if (cls == CLS_STORE) begin
                            pc    <= next_pc;
                            stage <= ST_FETCH;
                        end else begin
                            stage <= ST_WRITEBACK;
                        end
                    end
                    ST_WRITEBACK: begin
                        pc    <= next_pc;
                        stage <= ST_FETCH;
                    end
                    default: stage <= ST_FETCH;
                endcase
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (advance && stage == ST_FETCH) begin
            mem_addr <= pc;
        end else if (access) begin
            mem_addr <= alu_result;
        end
        if (mem_valid && i_mem_ready) begin
            mem_rdata <= i_mem_data;
        end
    end

    assign o_mem_valid = mem_valid;
    assign o_mem_addr  = mem_addr;
    assign o_mem_data  = store_data;
    assign o_mem_wen   = mem_rw ? store_wen : 4'b0000;

    rv_decode u_decode (
        .i_clk(i_clk), .i_rst(i_rst), .i_capture(capture), .i_instr(mem_rdata),
        .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd), .o_imm(imm), .o_class(cls),
        .o_alu_op(alu_op), .o_op1_is_pc(op1_is_pc), .o_op2_sel(op2_sel),
        .o_branch_cond(branch_cond), .o_mem_size(mem_size), .o_mem_unsigned(mem_unsigned)
    );

    rv_regfile u_regfile (
        .i_clk(i_clk), .i_rst(i_rst), .i_we(rf_we), .i_waddr(rd), .i_wdata(wb_data),
        .i_raddr1(rs1), .i_raddr2(rs2), .o_rdata1(rs1_val), .o_rdata2(rs2_val)
    );

    rv_execute u_execute (
        .i_clk(i_clk), .i_prepare(prepare), .i_execute(execute), .i_pc(pc),
        .i_rs1_val(rs1_val), .i_rs2_val(rs2_val), .i_imm(imm), .i_shamt(rs2),
        .i_alu_op(alu_op), .i_op1_is_pc(op1_is_pc), .i_op2_sel(op2_sel),
        .i_branch_cond(branch_cond), .o_alu_result(alu_result), .o_branch_taken(branch_taken)
    );

    rv_result u_result (
        .i_clk(i_clk), .i_access(access), .i_class(cls), .i_addr(alu_result),
        .i_rs2_val(rs2_val), .i_load_data(mem_rdata), .i_alu_result(alu_result),
        .i_imm(imm), .i_link(pc_inc), .i_mem_size(mem_size), .i_mem_unsigned(mem_unsigned),
        .o_store_data(store_data), .o_store_wen(store_wen), .o_wb_data(wb_data),
        .o_wb_en(wb_en)
    );

endmodule

`default_nettype wire

// ==== verification/tb_rv_core.sv ====
/*
 * Testbench for the RV32I core: memory model with random ready,
 * instruction encoders, test programs, reference model and checker.
 */

`timescale 1ns/1ns
`default_nettype none

`include "rv_core_params.svh"

module tb_rv_core
    import rv_core_pkg::*;
();

    localparam word_t RES_BASE    = 32'h8000_2000;
    localparam word_t DATA_BASE   = 32'h8000_1000;
    localparam word_t NARROW_BASE = 32'h8000_1800;
    localparam int    TIMEOUT     = 20000;

    logic     clk, rst, mem_ready, mem_valid;
    word_t    mem_rdata, mem_addr, mem_wdata;
    byte_en_t mem_wen;

    word_t    mem [4096];
    int       ptr, res_k, checked, exp_total, wait_cnt;
    logic     pending, first_fetch, seq_check;
    word_t    req_addr, req_data, prev_fetch, loop_addr;
    byte_en_t req_wen;
    word_t    exp_addr[$], exp_data[$], obs_addr[$], obs_data[$];
    byte_en_t exp_wen[$], obs_wen[$];
    string    exp_name[$];

    rv_core uut (
        .i_clk(clk), .i_rst(rst), .o_mem_valid(mem_valid), .i_mem_ready(mem_ready),
        .o_mem_addr(mem_addr), .i_mem_data(mem_rdata), .o_mem_data(mem_wdata),
        .o_mem_wen(mem_wen)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input word_t expv, input word_t actv);
        abort_run($sformatf("FAIL %s expected %h actual %h", name, expv, actv));
    endtask

    function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t enc_b(input logic [12:0] off, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_j(input logic [20:0] off, input reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // Expected RV32I results, written from the instruction set rules.
    function automatic word_t ref_alu(input logic [2:0] f3, input logic alt, input word_t a,
                                      input word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic ref_branch(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic word_t ref_load(input logic [2:0] f3, input word_t w, input logic [1:0] off);
        word_t sh;
        sh = w >> {off, 3'b000};
        case (f3[1:0])
            2'd0:    return {{24{sh[7] & !f3[2]}}, sh[7:0]};
            2'd1:    return {{16{sh[15] & !f3[2]}}, sh[15:0]};
            default: return w;
        endcase
    endfunction

    // Returns the enable mask above the lane-placed store data.
    function automatic logic [35:0] ref_store(input logic [2:0] f3, input logic [1:0] off,
                                              input word_t v);
        int       lo, nbytes;
        byte_en_t en;
        word_t    data;
        lo = int'(off);
        nbytes = 1 << f3[1:0];
        en = '0;
        data = '0;
        for (int b = 0; b < 4; b++) begin
            if (b >= lo && b < lo + nbytes) begin
                en[b] = 1'b1;
                data[8*b +: 8] = v[8*(b-lo) +: 8];
            end
        end
        return {en, data};
    endfunction

    function automatic word_t lane_mask(input byte_en_t w);
        return {{8{w[3]}}, {8{w[2]}}, {8{w[1]}}, {8{w[0]}}};
    endfunction

    task automatic emit(input word_t w);
        mem[ptr] = w;
        ptr++;
    endtask

    task automatic load_const(input reg_idx_t rd, input word_t val);
        word_t up;
        up = val + 32'h800;
        emit({up[31:12], rd, OPC_LUI});
        emit(enc_i(val[11:0], rd, 3'd0, rd, OPC_OP_IMM));
    endtask

    task automatic expect_store(input word_t addr, input word_t data, input byte_en_t wen,
                                input string name);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_wen.push_back(wen);
        exp_name.push_back(name);
        exp_total++;
    endtask

    task automatic store_result(input reg_idx_t rs, input word_t expv, input string name);
        emit(enc_s(12'(4 * res_k), rs, 5'd10, 3'b010));
        expect_store(RES_BASE + word_t'(4 * res_k), expv, 4'b1111, name);
        res_k++;
    endtask

    // Holds the core in reset while the next program is written.
    task automatic begin_test(input logic seq);
        @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        exp_addr.delete();
        exp_data.delete();
        exp_wen.delete();
        exp_name.delete();
        exp_total = 0;
        checked = 0;
        ptr = 0;
        res_k = 0;
        seq_check = seq;
        for (int i = 0; i < 4096; i++) begin
            mem[i] = {i[11:0] ^ 12'ha5c, 4'h3, ~i[11:0], 4'hc};
        end
        for (int i = 1024; i < 1544; i++) begin
            mem[i] = $urandom;
        end
        load_const(5'd10, RES_BASE);
        load_const(5'd11, DATA_BASE);
        load_const(5'd12, NARROW_BASE);
    endtask

    task automatic finish_test(input string name);
        int cycles;
        loop_addr = `RV_PC_START + word_t'(4 * ptr);
        emit(enc_j(21'd0, 5'd0));
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!mem_valid && mem_wen == 4'b0000) else begin
            abort_run("memory request active right after reset");
        end
        cycles = 0;
        while (checked < exp_total && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (checked < exp_total) begin
            abort_run($sformatf("timeout in test %s waiting for stores", name));
        end
    endtask

    // Memory model: ready after 1 to 4 cycles, writes applied on the handshake.
    always @(posedge clk) begin
        if (rst) begin
            mem_ready <= 1'b0;
            pending = 1'b0;
            first_fetch = 1'b1;
        end else if (mem_valid) begin
            if (!pending) begin
                pending = 1'b1;
                req_addr = mem_addr;
                req_data = mem_wdata;
                req_wen = mem_wen;
                wait_cnt = $urandom % 4;
                assert (mem_addr[31:14] == 18'h20000) else begin
                    abort_run("request address outside the memory model");
                end
                if (mem_wen == 4'b0000 && mem_addr < DATA_BASE) begin
                    if (first_fetch) begin
                        assert (mem_addr == `RV_PC_START) else begin
                            report_mismatch("first fetch", `RV_PC_START, mem_addr);
                        end
                        first_fetch = 1'b0;
                    end else if (seq_check && prev_fetch != loop_addr) begin
                        assert (mem_addr == prev_fetch + 32'd4) else begin
                            report_mismatch("fetch order", prev_fetch + 32'd4, mem_addr);
                        end
                    end
                    prev_fetch = mem_addr;
                end
            end else begin
                assert (mem_addr == req_addr && mem_wdata == req_data && mem_wen == req_wen)
                else begin
                    abort_run("request changed while waiting for ready");
                end
            end
            if (mem_ready) begin
                mem_ready <= 1'b0;
                pending = 1'b0;
            end else if (wait_cnt == 0) begin
                mem_ready <= 1'b1;
                mem_rdata <= mem[mem_addr[13:2]];
                if (mem_wen != 4'b0000) begin
                    mem[mem_addr[13:2]] = (mem[mem_addr[13:2]] & ~lane_mask(mem_wen)) |
                                          (mem_wdata & lane_mask(mem_wen));
                    obs_addr.push_back(mem_addr);
                    obs_data.push_back(mem_wdata);
                    obs_wen.push_back(mem_wen);
                end
            end else begin
                wait_cnt--;
            end
        end
    end

    // Compares each observed store with the next expected one.
    always @(negedge clk) begin
        word_t    oa, od, ea, ed;
        byte_en_t ow, ew;
        string    nm;
        if (obs_addr.size() > 0) begin
            oa = obs_addr.pop_front();
            od = obs_data.pop_front();
            ow = obs_wen.pop_front();
            if (exp_addr.size() == 0) begin
                abort_run($sformatf("unexpected store to %h", oa));
            end else begin
                ea = exp_addr.pop_front();
                ed = exp_data.pop_front();
                ew = exp_wen.pop_front();
                nm = exp_name.pop_front();
                assert (oa == ea) else report_mismatch({nm, " address"}, ea, oa);
                assert (ow == ew) else report_mismatch({nm, " enables"}, {28'b0, ew}, {28'b0, ow});
                assert ((od & lane_mask(ew)) == (ed & lane_mask(ew))) else begin
                    report_mismatch({nm, " data"}, ed & lane_mask(ew), od & lane_mask(ew));
                end
                checked++;
            end
        end
    end

    initial begin
        word_t       a, b, imm_val, pj, v;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        alt;
        logic [35:0] st;
        int          k;
        logic [2:0]  conds [6];
        logic [2:0]  loads [5];
        void'($urandom(32'h3acf41e1));
        conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        loads = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        rst = 1'b1;
        mem_ready = 1'b0;
        mem_rdata = '0;
        loop_addr = '0;
        prev_fetch = '0;

        begin_test(1'b1);
        for (int i = 0; i < 19; i++) begin
            a = $urandom;
            b = $urandom;
            load_const(5'd1, a);
            load_const(5'd2, b);
            if (i < 10) begin
                f3 = (i < 8) ? 3'(i) : ((i == 8) ? 3'd0 : 3'd5);
                alt = (i >= 8);
                emit(enc_r(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3));
                store_result(5'd3, ref_alu(f3, alt, a, b), $sformatf("reg op %0d", i));
            end else begin
                f3 = (i < 18) ? 3'(i - 10) : 3'd5;
                alt = (i == 18);
                imm = (f3[1:0] == 2'b01) ? {alt ? 7'h20 : 7'h00, b[4:0]} : b[11:0];
                imm_val = {{20{imm[11]}}, imm};
                emit(enc_i(imm, 5'd1, f3, 5'd3, OPC_OP_IMM));
                store_result(5'd3, ref_alu(f3, alt, a, imm_val), $sformatf("imm op %0d", i));
            end
        end
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
        store_result(5'd0, 32'd0, "write to x0");
        finish_test("alu");

        begin_test(1'b0);
        for (int i = 0; i < 12; i++) begin
            a = $urandom;
            b = (i < 6) ? a : $urandom;
            load_const(5'd1, a);
            load_const(5'd2, b);
            emit(enc_i(12'd1, 5'd0, 3'd0, 5'd3, OPC_OP_IMM));
            emit(enc_b(13'd8, 5'd2, 5'd1, conds[i % 6]));
            emit(enc_i(12'd2, 5'd0, 3'd0, 5'd3, OPC_OP_IMM));
            store_result(5'd3, ref_branch(conds[i % 6], a, b) ? 32'd1 : 32'd2,
                         $sformatf("branch %0d", i));
        end
        emit(enc_i(12'd1, 5'd0, 3'd0, 5'd5, OPC_OP_IMM));
        pj = `RV_PC_START + word_t'(4 * ptr);
        emit(enc_j(21'd8, 5'd4));
        emit(enc_i(12'd7, 5'd0, 3'd0, 5'd5, OPC_OP_IMM));
        store_result(5'd4, pj + 32'd4, "jal link");
        store_result(5'd5, 32'd1, "jal skip");
        pj = `RV_PC_START + word_t'(4 * (ptr + 2));
        load_const(5'd6, pj + 32'd4);
        emit(enc_i(12'd4, 5'd6, 3'd0, 5'd7, OPC_JALR));
        emit(enc_i(12'd9, 5'd0, 3'd0, 5'd5, OPC_OP_IMM));
        store_result(5'd7, pj + 32'd4, "jalr link");
        store_result(5'd5, 32'd1, "jalr skip");
        finish_test("branch");

        begin_test(1'b0);
        k = 0;
        foreach (loads[j]) begin
            for (int off = 0; off < 4; off += (1 << loads[j][1:0])) begin
                emit(enc_i(12'(4 * k + off), 5'd11, loads[j], 5'd3, OPC_LOAD));
                store_result(5'd3, ref_load(loads[j], mem[1024 + k], 2'(off)),
                             $sformatf("load f3=%0d off=%0d", loads[j], off));
                k++;
            end
        end
        finish_test("load");

        begin_test(1'b0);
        k = 0;
        for (int s = 0; s < 2; s++) begin
            for (int off = 0; off < 4; off += (s + 1)) begin
                v = $urandom;
                load_const(5'd2, v);
                emit(enc_s(12'(4 * k + off), 5'd2, 5'd12, 3'(s)));
                st = ref_store(3'(s), 2'(off), v);
                expect_store(NARROW_BASE + word_t'(4 * k + off), st[31:0], st[35:32],
                             $sformatf("store f3=%0d off=%0d", s, off));
                k++;
            end
        end
        finish_test("store");

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+src
src/rv_core_pkg.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_core.sv
verification/tb_rv_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_rv_core
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
